// ==== logic/ctrlPkg.sv ====
package ctrlPkg;

	typedef enum logic [4:0] {
		stReset,
		stRegInit,
		stInitWait,
		stFetch,
		stFetchWait,
		stIrLoad,
		stDecode,
		stAluExec,
		stAluWait,
		stAluWrite,
		stJrExec,
		stJrJump,
		stBrTarget,
		stBrWait,
		stBrCompare,
		stBrTake
	} ctrlStateT;

	// passA forwards operand A untouched, used for jr
	typedef enum logic [2:0] {passA, add, sub, andOp, slt} aluOpT;

	typedef enum logic [0:0] {srcPc, srcRegA} aluSrcAT;

	typedef enum logic [1:0] {srcRegB, srcFour, srcImm, srcBranchOffset} aluSrcBT;

	typedef enum logic [1:0] {dstRt, dstRd, dstSp} regDstT;

	// wdStackInit selects the fixed stack pointer start value
	typedef enum logic [1:0] {wdAluOut, wdLessThan, wdStackInit} writeDataT;

	typedef enum logic [0:0] {pcAluResult, pcAluOut} pcSrcT;

	typedef enum logic [1:0] {condEq, condNe, condGt} branchCondT;

	typedef struct packed {
		logic       pcWrite;
		logic       pcWriteCond;
		branchCondT branchCond;
		pcSrcT      pcSrc;
		logic       irWrite;
		logic       regWrite;
		regDstT     regDst;
		writeDataT  writeData;
		aluSrcAT    aluSrcA;
		aluSrcBT    aluSrcB;
		aluOpT      aluOp;
		logic       aLoad;
		logic       bLoad;
		logic       aluOutLoad;
	} ctrlWordT;

	localparam ctrlWordT ctrlIdle = '{
		pcWrite:     1'b0,
		pcWriteCond: 1'b0,
		branchCond:  condEq,
		pcSrc:       pcAluResult,
		irWrite:     1'b0,
		regWrite:    1'b0,
		regDst:      dstRt,
		writeData:   wdAluOut,
		aluSrcA:     srcPc,
		aluSrcB:     srcRegB,
		aluOp:       passA,
		aLoad:       1'b0,
		bLoad:       1'b0,
		aluOutLoad:  1'b0
	};

endpackage

// ==== logic/ctrlSequencer.sv ====
`timescale 1ns/100ps

module ctrlSequencer (
	input  logic               clk,
	input  logic               rstN,
	input  isaPkg::instrClassT opClass,
	output ctrlPkg::ctrlStateT state,
	output logic               decodeEn
);
	import isaPkg::*;
	import ctrlPkg::*;

	ctrlStateT nextState;

	always_ff @(posedge clk)
	begin
		if (!rstN)
			state <= stReset;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = stFetch;
		case (state)
			stReset:     nextState = stRegInit;
			stRegInit:   nextState = stInitWait;
			stInitWait:  nextState = stFetch;

			stFetch:     nextState = stFetchWait;
			stFetchWait: nextState = stIrLoad;
			stIrLoad:    nextState = stDecode;

			// Only branch point of the FSM
			stDecode:
			begin
				case (opClass)
					clsAlu, clsImm: nextState = stAluExec;
					clsJump:        nextState = stJrExec;
					clsBranch:      nextState = stBrTarget;
					default:        nextState = stFetch;
				endcase
			end

			stAluExec:   nextState = stAluWait;
			stAluWait:   nextState = stAluWrite;
			stAluWrite:  nextState = stFetch;

			stJrExec:    nextState = stJrJump;
			stJrJump:    nextState = stFetch;

			stBrTarget:  nextState = stBrWait;
			stBrWait:    nextState = stBrCompare;
			stBrCompare: nextState = stBrTake;
			stBrTake:    nextState = stFetch;

			default:     nextState = stFetch;
		endcase
	end

	assign decodeEn = (state == stDecode);

endmodule

// ==== logic/ctrlUnit.sv ====
`timescale 1ns/100ps

module ctrlUnit (
	input  logic               clk,
	input  logic               rstN,
	input  isaPkg::instrFieldT opcode,
	input  isaPkg::instrFieldT funct,
	output ctrlPkg::ctrlWordT  ctrl
);
	import isaPkg::*;
	import ctrlPkg::*;

	instrClassT opClass;
	instrOpT    op;
	ctrlStateT  state;
	logic       decodeEn;

	instrDecoder decoder (
		.clk      (clk),
		.rstN     (rstN),
		.opcode   (opcode),
		.funct    (funct),
		.decodeEn (decodeEn),
		.opClass  (opClass),
		.op       (op)
	);

	ctrlSequencer sequencer (
		.clk      (clk),
		.rstN     (rstN),
		.opClass  (opClass),
		.state    (state),
		.decodeEn (decodeEn)
	);

	ctrlWordRom wordRom (
		.state (state),
		.op    (op),
		.ctrl  (ctrl)
	);

endmodule

// ==== logic/ctrlWordRom.sv ====
`timescale 1ns/100ps

module ctrlWordRom (
	input  ctrlPkg::ctrlStateT state,
	input  isaPkg::instrOpT    op,
	output ctrlPkg::ctrlWordT  ctrl
);
	import isaPkg::*;
	import ctrlPkg::*;

	// ALU function for the register and immediate sequence
	function automatic aluOpT aluOpFor(input instrOpT instrOp);
		aluOpT result;
		case (instrOp)
			opSub:   result = ctrlPkg::sub;
			opAnd:   result = ctrlPkg::andOp;
			opSlt:   result = ctrlPkg::slt;
			default: result = ctrlPkg::add;
		endcase
		return result;
	endfunction

	function automatic branchCondT branchCondFor(input instrOpT instrOp);
		branchCondT result;
		case (instrOp)
			opBne:   result = condNe;
			opBgt:   result = condGt;
			default: result = condEq;
		endcase
		return result;
	endfunction

	always_comb
	begin
		ctrl = ctrlIdle;
		case (state)
			// Load the stack pointer once after reset
			stRegInit:
			begin
				ctrl.regWrite  = 1'b1;
				ctrl.regDst    = dstSp;
				ctrl.writeData = wdStackInit;
			end

			// PC + 4
			stFetch:
			begin
				ctrl.pcWrite = 1'b1;
				ctrl.pcSrc   = pcAluResult;
				ctrl.aluSrcA = srcPc;
				ctrl.aluSrcB = srcFour;
				ctrl.aluOp   = ctrlPkg::add;
			end

			stIrLoad:
				ctrl.irWrite = 1'b1;

			stAluExec:
			begin
				ctrl.aLoad      = 1'b1;
				ctrl.bLoad      = 1'b1;
				ctrl.aluOutLoad = 1'b1;
				ctrl.aluSrcA    = srcRegA;
				ctrl.aluSrcB    = (op == opAddi) ? srcImm : srcRegB;
				ctrl.aluOp      = aluOpFor(op);
			end

			stAluWrite:
			begin
				ctrl.regWrite  = 1'b1;
				ctrl.regDst    = (op == opAddi) ? dstRt : dstRd;
				ctrl.writeData = (op == opSlt) ? wdLessThan : wdAluOut;
			end

			stJrExec:
			begin
				ctrl.aLoad      = 1'b1;
				ctrl.aluOutLoad = 1'b1;
				ctrl.aluSrcA    = srcRegA;
				ctrl.aluOp      = passA;
			end

			stJrJump:
			begin
				ctrl.pcWrite = 1'b1;
				ctrl.pcSrc   = pcAluOut;
			end

			// Target address computed before the compare
			stBrTarget:
			begin
				ctrl.aluOutLoad = 1'b1;
				ctrl.aluSrcA    = srcPc;
				ctrl.aluSrcB    = srcBranchOffset;
				ctrl.aluOp      = ctrlPkg::add;
			end

			stBrCompare:
			begin
				ctrl.aLoad   = 1'b1;
				ctrl.bLoad   = 1'b1;
				ctrl.aluSrcA = srcRegA;
				ctrl.aluSrcB = srcRegB;
				ctrl.aluOp   = (op == opBgt) ? ctrlPkg::slt : ctrlPkg::sub;
			end

			stBrTake:
			begin
				ctrl.pcWriteCond = 1'b1;
				ctrl.pcSrc       = pcAluOut;
				ctrl.branchCond  = branchCondFor(op);
			end

			default:
				ctrl = ctrlIdle;
		endcase
	end

endmodule

// ==== logic/instrDecoder.sv ====
`timescale 1ns/100ps

module instrDecoder (
	input  logic               clk,
	input  logic               rstN,
	input  isaPkg::instrFieldT opcode,
	input  isaPkg::instrFieldT funct,
	input  logic               decodeEn,
	output isaPkg::instrClassT opClass,
	output isaPkg::instrOpT    op
);
	import isaPkg::*;

	instrOpT decodedOp;

	always_comb
	begin
		decodedOp = opNone;
		case (opcode)
			rType:
			begin
				case (funct)
					add:     decodedOp = opAdd;
					sub:     decodedOp = opSub;
					andOp:   decodedOp = opAnd;
					slt:     decodedOp = opSlt;
					jr:      decodedOp = opJr;
					default: decodedOp = opNone;
				endcase
			end
			addi:    decodedOp = opAddi;
			beq:     decodedOp = opBeq;
			bne:     decodedOp = opBne;
			bgt:     decodedOp = opBgt;
			default: decodedOp = opNone;
		endcase
	end

	always_comb
	begin
		case (decodedOp)
			opAdd, opSub, opAnd, opSlt: opClass = clsAlu;
			opAddi:                     opClass = clsImm;
			opJr:                       opClass = clsJump;
			opBeq, opBne, opBgt:        opClass = clsBranch;
			default:                    opClass = clsNone;
		endcase
	end

	// Hold the operation so the execute states ignore later input changes
	always_ff @(posedge clk)
	begin
		if (!rstN)
			op <= opNone;
		else if (decodeEn)
			op <= decodedOp;
	end

endmodule

// ==== logic/isaPkg.sv ====
package isaPkg;

	localparam int fieldW = 6;

	// Raw opcode or funct field as it comes from the instruction register
	typedef logic [fieldW-1:0] instrFieldT;

	typedef enum logic [fieldW-1:0] {
		rType = 6'd0,
		beq   = 6'd4,
		bne   = 6'd5,
		bgt   = 6'd7,
		addi  = 6'd8
	} opcodeT;

	// Funct codes, only meaningful with opcode rType
	typedef enum logic [fieldW-1:0] {
		jr    = 6'd8,
		add   = 6'd32,
		sub   = 6'd34,
		andOp = 6'd36,
		slt   = 6'd42
	} functT;

	typedef enum logic [3:0] {
		opAdd,
		opSub,
		opAnd,
		opSlt,
		opAddi,
		opJr,
		opBeq,
		opBne,
		opBgt,
		opNone
	} instrOpT;

	// Which execution sequence follows decode
	typedef enum logic [2:0] {
		clsAlu,
		clsImm,
		clsJump,
		clsBranch,
		clsNone
	} instrClassT;

endpackage

// ==== run.sh ====
#!/bin/bash
cd "$(dirname "$0")" &&
verilator --binary --assert -f tb.f --top-module ctrlUnitTb -o ctrlUnitSim &&
./obj_dir/ctrlUnitSim | tee /dev/stderr | grep -q "Everything OK" &&
echo "Simulation passed" ||
{ echo "Simulation did not pass"; exit 1; }

// ==== tb.f ====
logic/isaPkg.sv
logic/ctrlPkg.sv
logic/instrDecoder.sv
logic/ctrlSequencer.sv
logic/ctrlWordRom.sv
logic/ctrlUnit.sv
tb/ctrlUnitTb.sv

// ==== tb/ctrlUnitTb.sv ====
`timescale 1ns/100ps

module ctrlUnitTb;
	import isaPkg::*;
	import ctrlPkg::*;

	localparam int numTests = 200;
	localparam int clkPeriod = 40;

	logic       clk;
	logic       rstN;
	instrFieldT opcode;
	instrFieldT funct;
	ctrlWordT   ctrl;

	// Reference model of the sequence
	ctrlStateT   expState;
	instrOpT     expOp;
	instrOpT     curOp;
	ctrlWordT    expWord;
	int          expGap;
	int          sinceFetch;
	logic        checkOn;
	logic        fetchNow;
	logic [31:0] rngState;
	logic [9:0]  opSeen;
	int          errorCount;
	int          errorsBefore;
	int          passCount;
	int          failCount;
	int          testsDone;

	ctrlUnit uut (.clk(clk), .rstN(rstN), .opcode(opcode), .funct(funct), .ctrl(ctrl));

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Cycles from one fetch to the next for each instruction kind
	function automatic int gapFor(input instrOpT o);
		int gap;
		case (o)
			opAdd, opSub, opAnd, opSlt, opAddi: gap = 7;
			opJr:                               gap = 6;
			opBeq, opBne, opBgt:                gap = 8;
			default:                            gap = 4;
		endcase
		return gap;
	endfunction

	function automatic ctrlStateT modelNext(input ctrlStateT s, input instrOpT o);
		ctrlStateT n;
		case (s)
			stReset:     n = stRegInit;
			stRegInit:   n = stInitWait;
			stFetch:     n = stFetchWait;
			stFetchWait: n = stIrLoad;
			stIrLoad:    n = stDecode;
			stDecode:
			begin
				if (gapFor(o) == 7)
					n = stAluExec;
				else if (gapFor(o) == 6)
					n = stJrExec;
				else if (gapFor(o) == 8)
					n = stBrTarget;
				else
					n = stFetch;
			end
			stAluExec:   n = stAluWait;
			stAluWait:   n = stAluWrite;
			stJrExec:    n = stJrJump;
			stBrTarget:  n = stBrWait;
			stBrWait:    n = stBrCompare;
			stBrCompare: n = stBrTake;
			default:     n = stFetch;
		endcase
		return n;
	endfunction

	// Field by field, each control asks which states drive it
	function automatic ctrlWordT expectedWord(input ctrlStateT s, input instrOpT o);
		ctrlWordT w;
		w.pcWrite     = s inside {stFetch, stJrJump};
		w.pcWriteCond = (s == stBrTake);
		w.branchCond  = (s != stBrTake) ? condEq : (o == opBne) ? condNe :
			(o == opBgt) ? condGt : condEq;
		w.pcSrc       = (s inside {stJrJump, stBrTake}) ? pcAluOut : pcAluResult;
		w.irWrite     = (s == stIrLoad);
		w.regWrite    = s inside {stRegInit, stAluWrite};
		w.regDst      = (s == stRegInit) ? dstSp : (s == stAluWrite && o != opAddi) ? dstRd : dstRt;
		w.writeData   = (s == stRegInit) ? wdStackInit :
			(s == stAluWrite && o == opSlt) ? wdLessThan : wdAluOut;
		w.aluSrcA     = (s inside {stAluExec, stJrExec, stBrCompare}) ? srcRegA : srcPc;
		w.aluSrcB     = (s == stFetch) ? srcFour : (s == stBrTarget) ? srcBranchOffset :
			(s == stAluExec && o == opAddi) ? srcImm : srcRegB;
		w.aluOp       = passA;
		if (s == stFetch || s == stBrTarget)
			w.aluOp = ctrlPkg::add;
		else if (s == stBrCompare)
			w.aluOp = (o == opBgt) ? ctrlPkg::slt : ctrlPkg::sub;
		else if (s == stAluExec)
			w.aluOp = (o == opSub) ? ctrlPkg::sub : (o == opAnd) ? ctrlPkg::andOp :
				(o == opSlt) ? ctrlPkg::slt : ctrlPkg::add;
		w.aLoad       = s inside {stAluExec, stJrExec, stBrCompare};
		w.bLoad       = s inside {stAluExec, stBrCompare};
		w.aluOutLoad  = s inside {stAluExec, stJrExec, stBrTarget};
		return w;
	endfunction

	// Chooses the next instruction and its encoding
	task automatic pickInstr;
		logic [31:0] r;
		int          sel;
		instrFieldT  code;
		rngState = xorshift32(rngState);
		r = rngState;
		sel = int'(r % 32'd11);
		code = r[23:18];
		opcode = isaPkg::rType;
		funct = r[17:12];
		case (sel)
			0:       curOp = opAdd;
			1:       curOp = opSub;
			2:       curOp = opAnd;
			3:       curOp = opSlt;
			4:       curOp = opJr;
			5:       curOp = opAddi;
			6:       curOp = opBeq;
			7:       curOp = opBne;
			8:       curOp = opBgt;
			default: curOp = opNone;
		endcase
		case (curOp)
			opAdd:  funct = isaPkg::add;
			opSub:  funct = isaPkg::sub;
			opAnd:  funct = isaPkg::andOp;
			opSlt:  funct = isaPkg::slt;
			opJr:   funct = isaPkg::jr;
			opAddi: opcode = isaPkg::addi;
			opBeq:  opcode = isaPkg::beq;
			opBne:  opcode = isaPkg::bne;
			opBgt:  opcode = isaPkg::bgt;
			default:
			begin
				if (sel == 9)
					opcode = (code inside {6'd0, 6'd4, 6'd5, 6'd7, 6'd8}) ? 6'd63 : code;
				else
					funct = (code inside {6'd8, 6'd32, 6'd34, 6'd36, 6'd42}) ? 6'd1 : code;
			end
		endcase
	endtask

	// Inputs only hold still while the DUT decodes
	task automatic driveInputs;
		if (expState == stDecode)
			pickInstr();
		else
		begin
			rngState = xorshift32(rngState);
			opcode = rngState[5:0];
			funct = rngState[11:6];
		end
	endtask

	task automatic closeTest;
		string name;
		if (testsDone == 0)
			name = "reset and start-up";
		else
		begin
			name = expOp.name();
			opSeen[expOp] = 1'b1;
		end
		if (errorCount > errorsBefore)
		begin
			failCount++;
			$display("test %0d %s: FAIL", testsDone, name);
		end
		else
		begin
			passCount++;
			$display("test %0d %s: pass", testsDone, name);
		end
		errorsBefore = errorCount;
		testsDone++;
	endtask

	assign expWord = expectedWord(expState, expOp);
	assign fetchNow = ctrl.pcWrite && ctrl.pcSrc == pcAluResult;

	always @(posedge clk)
	begin
		if (!rstN)
		begin
			expState <= stReset;
			expOp <= opNone;
			expGap <= 3;
			sinceFetch <= 0;
		end
		else
		begin
			expState <= modelNext(expState, curOp);
			sinceFetch <= fetchNow ? 1 : sinceFetch + 1;
			if (expState == stDecode)
			begin
				expOp <= curOp;
				expGap <= gapFor(curOp);
			end
			if (expState == stFetch)
				closeTest();
		end
	end

	wordCheck: assert property (@(negedge clk) disable iff (!checkOn) ctrl == expWord)
	else
	begin
		errorCount++;
		$display("MISMATCH at %0t: ctrl %h, expected %h in %s", $time, ctrl, expWord,
			expState.name());
	end

	periodCheck: assert property (@(negedge clk) disable iff (!checkOn)
		fetchNow |-> sinceFetch == expGap)
	else
	begin
		errorCount++;
		$display("MISMATCH at %0t: fetch after %0d cycles, expected %0d", $time,
			sinceFetch, expGap);
	end

	irLoadCheck: assert property (@(negedge clk) disable iff (!checkOn)
		ctrl.irWrite |-> sinceFetch == 2)
	else
	begin
		errorCount++;
		$display("MISMATCH at %0t: irWrite %0d cycles after fetch", $time, sinceFetch);
	end

	initial
	begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	initial
	begin
		#((numTests * 8 + 20) * clkPeriod);
		$display("Timeout: the instruction stream did not finish in time");
		$display("Something failed");
		$finish;
	end

	initial
	begin
		rstN = 1'b0;
		opcode = '0;
		funct = '0;
		curOp = opNone;
		checkOn = 1'b0;
		rngState = 32'hd34f;
		opSeen = '0;
		errorCount = 0;
		errorsBefore = 0;
		passCount = 0;
		failCount = 0;
		testsDone = 0;
		repeat (4)
		begin
			@(posedge clk);
			#1;
			checkOn = 1'b1;
			driveInputs();
		end
		rstN = 1'b1;
		while (testsDone < numTests + 1)
		begin
			@(posedge clk);
			#1;
			driveInputs();
		end
		if (opSeen != '1)
		begin
			errorCount++;
			$display("Not every instruction kind was exercised: %b", opSeen);
		end
		$display("tests passed %0d failed %0d", passCount, failCount);
		if (failCount == 0 && errorCount == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule
